// File: bench/csr_sva.sv
// bound to every csr_trap_regs instance; all properties are off while rst_n is low
`timescale 1ns/1ps

module csr_trap_sva (
  input logic                           clk,
  input logic                           rst_n,
  input logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input logic [csr_pkg::XLEN-1:0]       rdata_i,
  input logic [csr_pkg::XLEN-1:0]       pc_if_i,
  input logic [csr_pkg::XLEN-1:0]       pc_id_i,
  input logic                           csr_save_if_i,
  input logic                           csr_save_cause_i,
  input logic                           m_irq_enable_i,
  input logic [csr_pkg::XLEN-1:0]       mepc_i
);

  import csr_pkg::*;

  // MPP never leaves machine mode
  mpp_machine: assert property (@(posedge clk) disable iff (!rst_n)
    (csr_addr_i == CSR_MSTATUS) |-> (rdata_i[MSTATUS_MPP_LSB +: 2] == PRIV_LVL_M))
    else $error("mstatus MPP read back other than machine mode");

  // handler entry masks irqs
  irq_off_after_trap: assert property (@(posedge clk) disable iff (!rst_n)
    csr_save_cause_i |=> !m_irq_enable_i)
    else $error("irq enable still set after trap save");

  // IF pc when flagged, ID pc otherwise
  mepc_after_trap: assert property (@(posedge clk) disable iff (!rst_n)
    csr_save_cause_i |=> (mepc_i == ($past(csr_save_if_i) ? $past(pc_if_i) : $past(pc_id_i))))
    else $error("mepc does not hold the saved pc after trap save");

endmodule

bind csr_trap_regs csr_trap_sva i_trap_sva (
  .clk              (clk),
  .rst_n            (rst_n),
  .csr_addr_i       (csr_addr_i),
  .rdata_i          (rdata_o),
  .pc_if_i          (pc_if_i),
  .pc_id_i          (pc_id_i),
  .csr_save_if_i    (csr_save_if_i),
  .csr_save_cause_i (csr_save_cause_i),
  .m_irq_enable_i   (m_irq_enable_o),
  .mepc_i           (mepc_o)
);

// File: bench/csr_tb.sv
// models only N_EXT_CNT=2 with the default misa; the cycle counter is checked as a lower bound only
`timescale 1ns/1ps

module csr_tb;

  import csr_pkg::*;

  localparam int unsigned N_CNT       = N_FIXED_EVENTS + 2;  // 7 fixed + 2 external
  localparam logic [31:0] BOOT_ADDR   = 32'h1c00_8000;
  localparam logic [31:0] MISA_EXP    = 32'h4000_1104;       // MXL=1, M, I, C
  localparam logic [3:0]  CORE_ID     = 4'h5;
  localparam logic [5:0]  CLUSTER_ID  = 6'h2a;
  localparam logic [31:0] MHARTID_EXP = 32'h0000_0545;       // cluster 0x2a at 10:5, core 5 at 3:0
  localparam logic [11:0] RO_ADDR [5] = '{CSR_MISA, CSR_MTVEC, CSR_MHARTID, 12'h123, 12'h7a5};
  localparam int          TRAP_IF = 0;
  localparam int          TRAP_ID = 1;
  localparam int          MRET    = 2;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        csr_access;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  csr_op_e     csr_op;
  logic [31:0] csr_rdata;
  logic [31:0] pc_if;
  logic [31:0] pc_id;
  logic        save_if;
  logic        save_id;
  logic        save_cause;
  logic        restore_mret;
  logic [5:0]  cause;
  logic        m_irq_enable;
  logic [31:0] mepc;
  logic        mem_load;
  logic        mem_store;
  logic [1:0]  ext_cnt;

  integer seed = 79;
  int     mismatch_cnt = 0;
  int     other_cnt = 0;

  // reference model state
  logic             mie_m;
  logic             mpie_m;
  logic [31:0]      mepc_m;
  logic [31:0]      mcause_m;  // kept in read layout
  logic [N_CNT-1:0] pcer_m;
  logic [1:0]       pcmr_m;
  logic [31:0]      cnt_m [N_CNT];

  always #5 clk = ~clk;

  csr_file_top #(
    .N_EXT_CNT (2),
    .RV32E     (1'b0),
    .RV32M     (1'b1)
  ) dut0 (
    .clk (clk), .rst_n (rst_n),
    .csr_access_i (csr_access), .csr_addr_i (csr_addr), .csr_wdata_i (csr_wdata),
    .csr_op_i (csr_op), .csr_rdata_o (csr_rdata),
    .boot_addr_i (BOOT_ADDR), .core_id_i (CORE_ID), .cluster_id_i (CLUSTER_ID),
    .pc_if_i (pc_if), .pc_id_i (pc_id),
    .csr_save_if_i (save_if), .csr_save_id_i (save_id), .csr_save_cause_i (save_cause),
    .csr_restore_mret_i (restore_mret), .csr_cause_i (cause),
    .m_irq_enable_o (m_irq_enable), .mepc_o (mepc),
    .if_valid_i (1'b0), .mem_load_i (mem_load), .mem_store_i (mem_store),
    .jump_i (1'b0), .branch_i (1'b0), .branch_taken_i (1'b0),
    .ext_counters_i (ext_cnt)
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] expected_rdata(input logic [11:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      CSR_MSTATUS: begin
        v[3]     = mie_m;
        v[7]     = mpie_m;
        v[12:11] = 2'b11;  // MPP is machine only
      end
      CSR_MISA:    v = MISA_EXP;
      CSR_MTVEC:   v = BOOT_ADDR;
      CSR_MEPC:    v = mepc_m;
      CSR_MCAUSE:  v = mcause_m;
      CSR_MHARTID: v = MHARTID_EXP;
      CSR_PCER:    v[N_CNT-1:0] = pcer_m;
      CSR_PCMR:    v[1:0] = pcmr_m;
      default: begin
        // counter window; alias index 31 and empty slots give zero
        if (addr[11:5] == 7'h3c && 32'(addr[4:0]) < N_CNT) begin
          v = cnt_m[addr[4:0]];
        end
      end
    endcase
    return v;
  endfunction

  function automatic void apply_write(input logic [11:0] addr, input logic [31:0] v);
    case (addr)
      CSR_MSTATUS: begin
        mie_m  = v[3];
        mpie_m = v[7];
      end
      CSR_MEPC:   mepc_m   = v;
      CSR_MCAUSE: mcause_m = v & 32'h8000_001f;  // irq flag + 5 bit code
      CSR_PCER:   pcer_m   = v[N_CNT-1:0];
      CSR_PCMR:   pcmr_m   = v[1:0];
      default: begin
        if (addr[11:5] == 7'h3c) begin
          for (int c = 0; c < N_CNT; c++) begin
            if (addr == CSR_PCCR_ALL || 32'(addr[4:0]) == c) cnt_m[c] = v;
          end
        end
      end
    endcase
  endfunction

  function automatic void count_event(input int idx, input logic evt);
    if (evt && pcer_m[idx] && pcmr_m[0]) begin
      if (!(pcmr_m[1] && cnt_m[idx] == '1)) begin
        cnt_m[idx] = cnt_m[idx] + 32'd1;  // wraps when not saturating
      end
    end
  endfunction

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  // one access cycle whose write lands on the edge that ends it
  task automatic csr_rw(input csr_op_e op, input logic [11:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rd);
    logic [31:0] nv;
    @(posedge clk);
    csr_access <= 1'b1;
    csr_op     <= op;
    csr_addr   <= addr;
    csr_wdata  <= wdata;
    @(negedge clk);
    rd = csr_rdata;
    @(posedge clk);
    csr_access <= 1'b0;
    csr_op     <= CSR_OP_NONE;
    case (op)
      CSR_OP_WRITE: nv = wdata;
      CSR_OP_SET:   nv = expected_rdata(addr) | wdata;
      CSR_OP_CLEAR: nv = expected_rdata(addr) & ~wdata;
      default:      nv = '0;
    endcase
    if (op != CSR_OP_NONE) apply_write(addr, nv);
  endtask

  task automatic read_csr(input logic [11:0] addr);
    logic [31:0] rd;
    csr_rw(CSR_OP_NONE, addr, 32'h0, rd);
  endtask

  task automatic wait_irq(input logic exp);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (m_irq_enable !== exp && n < 4);
    if (m_irq_enable !== exp) begin
      other_cnt++;
      $display("timeout at %0t: m_irq_enable_o never reached %b", $time, exp);
    end
  endtask

  // trap save or mret that may race a software write to mstatus
  task automatic trap_event(input int kind, input bit with_wr, input logic [31:0] wd);
    logic [31:0] pi;
    logic [31:0] pd;
    logic [5:0]  c;
    pi = $random(seed) & 32'hffff_fffc;
    pd = $random(seed) & 32'hffff_fffc;
    c  = 6'($random(seed));
    @(posedge clk);
    pc_if        <= pi;
    pc_id        <= pd;
    cause        <= c;
    save_if      <= (kind == TRAP_IF);
    save_id      <= (kind == TRAP_ID);
    save_cause   <= (kind != MRET);
    restore_mret <= (kind == MRET);
    if (with_wr) begin
      csr_access <= 1'b1;
      csr_op     <= CSR_OP_WRITE;
      csr_addr   <= CSR_MSTATUS;
      csr_wdata  <= wd;
    end
    @(posedge clk);
    {save_if, save_id, save_cause, restore_mret} <= 4'b0;
    csr_access <= 1'b0;
    csr_op     <= CSR_OP_NONE;
    if (kind == MRET) begin
      mie_m  = mpie_m;
      mpie_m = 1'b1;
    end else begin
      mepc_m   = (kind == TRAP_IF) ? pi : pd;  // software write is dropped
      mcause_m = {c[5], 26'b0, c[4:0]};
      mpie_m   = mie_m;
      mie_m    = 1'b0;
    end
    wait_irq(mie_m);
  endtask

  // n random event cycles, then 3 quiet cycles to drain the increment pipe
  task automatic run_events(input int n);
    logic [31:0] r;
    for (int k = 0; k < n + 3; k++) begin
      @(posedge clk);
      r = (k < n) ? $random(seed) : 32'h0;
      mem_load  <= r[0];
      mem_store <= r[1];
      ext_cnt   <= r[3:2];
      count_event(2, r[0]);
      count_event(3, r[1]);
      count_event(7, r[2]);
      count_event(8, r[3]);
    end
  endtask

  //////////////////////////////////////////////////
  // comparison
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (csr_access && csr_addr != CSR_PCCR_BASE) begin  // cycle count is free running
        assert (csr_rdata === expected_rdata(csr_addr)) else begin
          mismatch_cnt++;
          $display("MISMATCH at %0t: csr %h read %h, expected %h",
                   $time, csr_addr, csr_rdata, expected_rdata(csr_addr));
        end
      end
      assert (m_irq_enable === mie_m && mepc === mepc_m) else begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: irq_en %b mepc %h, expected %b %h",
                 $time, m_irq_enable, mepc, mie_m, mepc_m);
      end
    end
  end

  initial begin
    for (int t = 0; t < 20000; t++) @(posedge clk);
    other_cnt++;
    $display("timeout: simulation ran past its cycle limit");
    $display("Test FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] c0;
    logic [31:0] c1;
    logic [11:0] addr;
    rst_n = 1'b0;
    csr_access = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    csr_op = CSR_OP_NONE;
    {pc_if, pc_id, cause} = '0;
    {save_if, save_id, save_cause, restore_mret} = 4'b0;
    {mem_load, mem_store, ext_cnt} = '0;
    {mie_m, mpie_m, mepc_m, mcause_m, pcer_m} = '0;
    pcmr_m = 2'b11;  // enabled, saturating
    for (int c = 0; c < N_CNT; c++) cnt_m[c] = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // random write / set / clear / none on the trap registers
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    addr = CSR_MSTATUS;
        2'd1:    addr = CSR_MEPC;
        default: addr = CSR_MCAUSE;
      endcase
      csr_rw(csr_op_e'(r[3:2]), addr, $random(seed), c0);
      read_csr(addr);
    end

    // read-only and unclaimed addresses
    foreach (RO_ADDR[i]) begin
      read_csr(RO_ADDR[i]);
      csr_rw(CSR_OP_WRITE, RO_ADDR[i], $random(seed), c0);
      csr_rw(CSR_OP_SET, RO_ADDR[i], $random(seed), c0);
      read_csr(RO_ADDR[i]);
    end

    // trap entry from IF then ID, a losing mstatus write, mret
    csr_rw(CSR_OP_WRITE, CSR_MSTATUS, 32'h8, c0);
    trap_event(TRAP_IF, 1'b0, 32'h0);
    csr_rw(CSR_OP_SET, CSR_MSTATUS, 32'h8, c0);
    trap_event(TRAP_ID, 1'b0, 32'h0);
    csr_rw(CSR_OP_WRITE, CSR_MSTATUS, 32'h88, c0);
    trap_event(TRAP_ID, 1'b1, 32'h0);
    read_csr(CSR_MSTATUS);
    read_csr(CSR_MCAUSE);
    trap_event(MRET, 1'b0, 32'h0);
    csr_rw(CSR_OP_WRITE, CSR_MSTATUS, 32'h8, c0);
    trap_event(MRET, 1'b0, 32'h0);
    read_csr(CSR_MSTATUS);

    // cycle, load, store and both external counters
    csr_rw(CSR_OP_WRITE, CSR_PCER, 32'h18d, c0);
    csr_rw(CSR_OP_NONE, CSR_PCCR_BASE, 32'h0, c0);
    run_events(20);
    csr_rw(CSR_OP_NONE, CSR_PCCR_BASE, 32'h0, c1);
    assert (c1 - c0 >= 32'd20) else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: cycle counter advanced %0d, expected at least 20",
               $time, c1 - c0);
    end
    for (int c = 1; c < N_CNT; c++) read_csr(12'(CSR_PCCR_BASE + c));

    // global enable off, then saturate, then wrap
    csr_rw(CSR_OP_CLEAR, CSR_PCMR, 32'h1, c0);
    run_events(10);
    for (int c = 2; c < N_CNT; c++) read_csr(12'(CSR_PCCR_BASE + c));
    csr_rw(CSR_OP_SET, CSR_PCMR, 32'h1, c0);
    csr_rw(CSR_OP_WRITE, 12'h782, 32'hffff_ffff, c0);
    run_events(8);
    read_csr(12'h782);
    csr_rw(CSR_OP_WRITE, CSR_PCMR, 32'h1, c0);
    csr_rw(CSR_OP_WRITE, 12'h782, 32'hffff_ffff, c0);
    run_events(8);
    read_csr(12'h782);
    read_csr(CSR_PCMR);

    // write alias hits every counter and reads back zero
    csr_rw(CSR_OP_WRITE, CSR_PCCR_ALL, $random(seed), c0);
    for (int c = 1; c < N_CNT; c++) read_csr(12'(CSR_PCCR_BASE + c));
    read_csr(CSR_PCCR_ALL);
    read_csr(12'h790);

    @(posedge clk);
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f src.f -o csr_sim
./obj_dir/csr_sim 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: source/csr_access_ctrl.sv
// single cycle access, no back-pressure; blocks must never claim the same address, first hit wins
`timescale 1ns/1ps

module csr_access_ctrl (
  // port from the core
  input  logic                           csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  input  csr_pkg::csr_op_e               csr_op_i,
  output logic [csr_pkg::XLEN-1:0]       csr_rdata_o,

  // read return from the register blocks
  input  logic [csr_pkg::XLEN-1:0]       trap_rdata_i,
  input  logic                           trap_hit_i,
  input  logic [csr_pkg::XLEN-1:0]       perf_rdata_i,
  input  logic                           perf_hit_i,

  // shared write side towards the register blocks
  output logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_o,
  output logic                           csr_we_o,
  output logic [csr_pkg::XLEN-1:0]       csr_wdata_o
);

  import csr_pkg::*;

  logic [XLEN-1:0] cur_val;    // current read value of the addressed csr
  logic            op_writes;  // op changes state

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////

  // hit flags come from each block's own decoder
  always_comb begin
    cur_val = '0;  // unmapped address reads zero
    if (trap_hit_i) begin
      cur_val = trap_rdata_i;
    end else if (perf_hit_i) begin
      cur_val = perf_rdata_i;
    end
  end

  assign csr_rdata_o = cur_val;  // combinational, same cycle

  //////////////////////////////////////////////////
  // write data and enable
  //////////////////////////////////////////////////

  assign op_writes = (csr_op_i != CSR_OP_NONE);
  assign csr_we_o  = csr_access_i & op_writes;  // lands on next edge

  // set and clear always merge with the value as read
  always_comb begin
    unique case (csr_op_i)
      CSR_OP_WRITE: csr_wdata_o = csr_wdata_i;
      CSR_OP_SET:   csr_wdata_o = cur_val | csr_wdata_i;
      CSR_OP_CLEAR: csr_wdata_o = cur_val & ~csr_wdata_i;
      default:      csr_wdata_o = csr_wdata_i;  // none, we is low anyway
    endcase
  end

  // one shared address bus, decoding stays in the blocks
  assign csr_addr_o = csr_addr_i;

endmodule

// File: source/csr_file_top.sv
// one access per cycle, reads same cycle, writes and trap updates at the next rising clk
`timescale 1ns/1ps

module csr_file_top #(
  parameter int unsigned N_EXT_CNT = 2,     // 0..8 external events
  parameter bit          RV32E     = 1'b0,  // misa E
  parameter bit          RV32M     = 1'b1   // misa M
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // csr access port
  input  logic                           csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  input  csr_pkg::csr_op_e               csr_op_i,
  output logic [csr_pkg::XLEN-1:0]       csr_rdata_o,

  input  logic [csr_pkg::XLEN-1:0]       boot_addr_i,
  input  logic [3:0]                     core_id_i,
  input  logic [5:0]                     cluster_id_i,

  // traps
  input  logic [csr_pkg::XLEN-1:0]       pc_if_i,
  input  logic [csr_pkg::XLEN-1:0]       pc_id_i,
  input  logic                           csr_save_if_i,
  input  logic                           csr_save_id_i,
  input  logic                           csr_save_cause_i,
  input  logic                           csr_restore_mret_i,
  input  logic [csr_pkg::MCAUSE_W-1:0]   csr_cause_i,
  output logic                           m_irq_enable_o,
  output logic [csr_pkg::XLEN-1:0]       mepc_o,

  // perf events
  input  logic                           if_valid_i,
  input  logic                           mem_load_i,
  input  logic                           mem_store_i,
  input  logic                           jump_i,
  input  logic                           branch_i,
  input  logic                           branch_taken_i,
  input  logic [N_EXT_CNT-1:0]           ext_counters_i
);

  import csr_pkg::*;

  logic [CSR_ADDR_W-1:0] csr_addr;       // shared address
  logic                  csr_we;
  logic [XLEN-1:0]       csr_wdata_eff;  // after set/clear merge
  logic [XLEN-1:0]       trap_rdata;
  logic                  trap_hit;
  logic [XLEN-1:0]       perf_rdata;
  logic                  perf_hit;

  csr_access_ctrl i_access_ctrl (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_op_i     (csr_op_i),
    .csr_rdata_o  (csr_rdata_o),
    .trap_rdata_i (trap_rdata),
    .trap_hit_i   (trap_hit),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit),
    .csr_addr_o   (csr_addr),
    .csr_we_o     (csr_we),
    .csr_wdata_o  (csr_wdata_eff)
  );

  csr_trap_regs #(
    .RV32E (RV32E),
    .RV32M (RV32M)
  ) i_trap_regs (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_addr_i         (csr_addr),
    .csr_we_i           (csr_we),
    .csr_wdata_i        (csr_wdata_eff),
    .rdata_o            (trap_rdata),
    .hit_o              (trap_hit),
    .boot_addr_i        (boot_addr_i),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .m_irq_enable_o     (m_irq_enable_o),
    .mepc_o             (mepc_o)
  );

  csr_perf_counters #(
    .N_EXT_CNT (N_EXT_CNT)
  ) i_perf_counters (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr),
    .csr_we_i       (csr_we),
    .csr_wdata_i    (csr_wdata_eff),
    .rdata_o        (perf_rdata),
    .hit_o          (perf_hit),
    .if_valid_i     (if_valid_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .jump_i         (jump_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .ext_counters_i (ext_counters_i)
  );

endmodule

// File: source/csr_perf_counters.sv
// counters lag their event by two edges; N_EXT_CNT up to 8, at 0 the ext_counters_i port is ignored
`timescale 1ns/1ps

module csr_perf_counters #(
  parameter int unsigned N_EXT_CNT = 2
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // shared write side
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic                           csr_we_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  output logic [csr_pkg::XLEN-1:0]       rdata_o,
  output logic                           hit_o,

  // events, one cycle high per occurrence
  input  logic                           if_valid_i,      // new instr from IF
  input  logic                           mem_load_i,
  input  logic                           mem_store_i,
  input  logic                           jump_i,          // j, jal, jalr
  input  logic                           branch_i,        // conditional
  input  logic                           branch_taken_i,
  input  logic [N_EXT_CNT-1:0]           ext_counters_i
);

  import csr_pkg::*;

  localparam int unsigned N_CNT = N_FIXED_EVENTS + N_EXT_CNT;

  logic [N_CNT-1:0]           evt_in;     // raw event per counter
  logic [N_CNT-1:0]           cnt_inc;    // gated by pcer and pcmr
  logic [N_CNT-1:0]           cnt_inc_q;  // registered, applied next edge
  logic [N_CNT-1:0][XLEN-1:0] cnt_q;
  logic [N_CNT-1:0][XLEN-1:0] cnt_n;
  logic [N_CNT-1:0]           pcer_q;     // per event enable
  logic [1:0]                 pcmr_q;     // [1] saturate, [0] global enable

  logic       is_pccr;   // 0x780..0x79F
  logic       is_all;    // alias 0x79F
  logic       is_pcer;
  logic       is_pcmr;
  logic [4:0] pccr_idx;  // counter index within the window

  //////////////////////////////////////////////////
  // event mapping
  //////////////////////////////////////////////////

  assign evt_in[0] = 1'b1;            // cycles
  assign evt_in[1] = if_valid_i;      // instructions
  assign evt_in[2] = mem_load_i;
  assign evt_in[3] = mem_store_i;
  assign evt_in[4] = jump_i;
  assign evt_in[5] = branch_i;
  assign evt_in[6] = branch_taken_i;

  for (genvar i = 0; i < N_EXT_CNT; i++) begin : g_ext_evt
    assign evt_in[N_FIXED_EVENTS+i] = ext_counters_i[i];
  end

  assign cnt_inc = evt_in & pcer_q & {N_CNT{pcmr_q[0]}};

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign is_pccr  = (csr_addr_i[CSR_ADDR_W-1:5] == PCCR_BASE_MASK);
  assign is_all   = (csr_addr_i == CSR_PCCR_ALL);
  assign is_pcer  = (csr_addr_i == CSR_PCER);
  assign is_pcmr  = (csr_addr_i == CSR_PCMR);
  assign pccr_idx = 5'(csr_addr_i - CSR_PCCR_BASE);

  assign hit_o = is_pccr | is_pcer | is_pcmr;  // whole window claimed

  // alias and unused indexes read zero
  always_comb begin
    rdata_o = '0;
    if (is_pcer) begin
      rdata_o[N_CNT-1:0] = pcer_q;
    end else if (is_pcmr) begin
      rdata_o[1:0] = pcmr_q;
    end else if (is_pccr && !is_all && (pccr_idx < N_CNT)) begin
      rdata_o = cnt_q[pccr_idx];
    end
  end

  //////////////////////////////////////////////////
  // counter update
  //////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < N_CNT; c++) begin
      cnt_n[c] = cnt_q[c];
      // hold at all ones when saturating, wrap otherwise
      if (cnt_inc_q[c] && (!pcmr_q[1] || (cnt_q[c] != '1))) begin
        cnt_n[c] = cnt_q[c] + XLEN'(1);
      end
      // software write overrides a pending increment
      if (csr_we_i && is_pccr && (is_all || (pccr_idx == 5'(c)))) begin
        cnt_n[c] = csr_wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q    <= '0;
      pcmr_q    <= PCMR_RESET;  // enabled, saturating
      cnt_inc_q <= '0;
      cnt_q     <= '0;
    end else begin
      if (csr_we_i && is_pcer) begin
        pcer_q <= csr_wdata_i[N_CNT-1:0];
      end
      if (csr_we_i && is_pcmr) begin
        pcmr_q <= csr_wdata_i[1:0];
      end
      cnt_inc_q <= cnt_inc;  // first edge
      cnt_q     <= cnt_n;    // second edge
    end
  end

endmodule

// File: source/csr_pkg.sv
// rv32 machine mode only; counter indexes must stay below 31 so the alias at 0x79F is never a real counter
package csr_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned CSR_ADDR_W = 12;   // csr number width
  localparam int unsigned XLEN       = 32;   // data width
  localparam int unsigned MCAUSE_W   = 6;    // irq flag on top, 5 bit code below

  // access operation, encoded as the core's csr instruction decoder gives it
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,  // read only
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////////////////////////
  // addresses
  //////////////////////////////////////////////////

  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MTVEC     = 12'h305,  // read only here, boot address
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_PCCR_BASE = 12'h780,  // counter 0
    CSR_PCCR_ALL  = 12'h79F,  // write alias for every counter
    CSR_PCER      = 12'h7A0,  // per event enable
    CSR_PCMR      = 12'h7A1,  // global enable + saturate
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // addr[11:5] of the counter window 0x780..0x79F
  localparam logic [6:0] PCCR_BASE_MASK = 7'b0111100;

  //////////////////////////////////////////////////
  // mstatus layout
  //////////////////////////////////////////////////

  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;  // two bits, 12:11

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11   // the only level this core runs in
  } priv_lvl_e;

  //////////////////////////////////////////////////
  // performance counters
  //////////////////////////////////////////////////

  // cycle, instr, load, store, jump, branch, taken branch
  localparam int unsigned N_FIXED_EVENTS = 7;

  // bit 0 global enable, bit 1 saturate
  localparam logic [1:0] PCMR_RESET = 2'b11;

endpackage

// File: source/csr_trap_regs.sv
// machine mode only: MPP is hardwired to 3, mtvec is the boot address, trap save beats a software write
`timescale 1ns/1ps

module csr_trap_regs #(
  parameter bit RV32E = 1'b0,
  parameter bit RV32M = 1'b1
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // shared write side
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic                           csr_we_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  output logic [csr_pkg::XLEN-1:0]       rdata_o,
  output logic                           hit_o,

  // static config
  input  logic [csr_pkg::XLEN-1:0]       boot_addr_i,
  input  logic [3:0]                     core_id_i,
  input  logic [5:0]                     cluster_id_i,

  // trap control from the core
  input  logic [csr_pkg::XLEN-1:0]       pc_if_i,
  input  logic [csr_pkg::XLEN-1:0]       pc_id_i,
  input  logic                           csr_save_if_i,
  input  logic                           csr_save_id_i,
  input  logic                           csr_save_cause_i,
  input  logic                           csr_restore_mret_i,
  input  logic [csr_pkg::MCAUSE_W-1:0]   csr_cause_i,

  output logic                           m_irq_enable_o,
  output logic [csr_pkg::XLEN-1:0]       mepc_o
);

  import csr_pkg::*;

  // MXL=1, M bit 12, I bit 8, E bit 4, C bit 2
  localparam logic [XLEN-1:0] MISA_VALUE = {2'd1, 4'b0, 13'b0, RV32M, 3'b0,
                                            1'b1, 3'b0, RV32E, 1'b0, 1'b1, 2'b0};

  logic                mie_q;      // mstatus.MIE
  logic                mie_n;
  logic                mpie_q;     // mstatus.MPIE
  logic                mpie_n;
  logic [XLEN-1:0]     mepc_q;
  logic [XLEN-1:0]     mepc_n;
  logic [MCAUSE_W-1:0] mcause_q;   // {irq, code[4:0]}
  logic [MCAUSE_W-1:0] mcause_n;
  logic [XLEN-1:0]     exc_pc;     // pc saved on trap entry

  //////////////////////////////////////////////////
  // read side and address claim
  //////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        rdata_o[MSTATUS_MIE_BIT]       = mie_q;
        rdata_o[MSTATUS_MPIE_BIT]      = mpie_q;
        rdata_o[MSTATUS_MPP_LSB +: 2]  = PRIV_LVL_M;  // always machine
      end
      CSR_MISA:    rdata_o = MISA_VALUE;
      CSR_MTVEC:   rdata_o = boot_addr_i;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = {mcause_q[MCAUSE_W-1], {(XLEN-MCAUSE_W){1'b0}},
                              mcause_q[MCAUSE_W-2:0]};
      CSR_MHARTID: rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:     hit_o   = 1'b0;  // not ours
    endcase
  end

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  // if stage pc when asked for, id stage otherwise
  always_comb begin
    exc_pc = pc_id_i;
    if (csr_save_if_i) begin
      exc_pc = pc_if_i;
    end else if (csr_save_id_i) begin
      exc_pc = pc_id_i;
    end
  end

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    if (csr_save_cause_i) begin
      // trap entry, a software write in this cycle is dropped
      mepc_n   = exc_pc;
      mcause_n = csr_cause_i;
      mpie_n   = mie_q;
      mie_n    = 1'b0;   // irqs masked in handler
    end else begin
      if (csr_we_i) begin
        case (csr_addr_i)
          CSR_MSTATUS: begin
            mie_n  = csr_wdata_i[MSTATUS_MIE_BIT];
            mpie_n = csr_wdata_i[MSTATUS_MPIE_BIT];
          end
          CSR_MEPC:   mepc_n   = csr_wdata_i;
          CSR_MCAUSE: mcause_n = {csr_wdata_i[XLEN-1], csr_wdata_i[MCAUSE_W-2:0]};
          default: ;  // read-only or foreign address
        endcase
      end
      // mret wins over a write to mstatus
      if (csr_restore_mret_i) begin
        mie_n  = mpie_q;
        mpie_n = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  assign m_irq_enable_o = mie_q;
  assign mepc_o         = mepc_q;

endmodule

// File: src.f
source/csr_pkg.sv
source/csr_access_ctrl.sv
source/csr_trap_regs.sv
source/csr_perf_counters.sv
source/csr_file_top.sv
bench/csr_sva.sv
bench/csr_tb.sv
